/* Bender.yml */
package:
  name: core

sources:
  - verilog/core_pkg.sv
  - verilog/exec_bus_if.sv
  - verilog/fetch.sv
  - verilog/decode.sv
  - verilog/register.sv
  - verilog/exec.sv
  - verilog/core.sv
  - target: test
    files:
      - test/core_tb.sv

/* flist.f */
verilog/core_pkg.sv
verilog/exec_bus_if.sv
verilog/fetch.sv
verilog/decode.sv
verilog/register.sv
verilog/exec.sv
verilog/core.sv
test/core_tb.sv

/* test/core_tb.sv */
`timescale 1ns/1ns

module core_tb;
    import core_pkg::*;

    localparam word_t RESET_PC = '0;
    localparam int    SEED     = 3;

    logic      clk;
    logic      rst_n;
    logic      inst_rden;
    word_t     inst_riaddr;
    word_t     inst_roaddr;
    logic      inst_rvalid;
    word_t     inst_rdata;
    logic      mem_wait;
    logic      reg_w_valid;
    reg_addr_t reg_w_rd;
    word_t     reg_w_data;

    // program table, one entry per instruction word
    word_t     row_inst[$];
    bit        row_ret[$];
    reg_addr_t row_rd[$];
    word_t     row_val[$];
    bit        row_jmp[$];
    word_t     row_tgt[$];

    word_t     rom [0:255];
    reg_addr_t exp_rd[$];
    word_t     exp_val[$];
    int        exp_idx;
    int        errors;
    int        cycles;
    int        limit;
    logic      req_valid;
    word_t     req_addr;
    logic      prev_rden;
    word_t     prev_addr;
    word_t     model_pc;
    int        row_idx;
    int        due_cyc[$];
    word_t     due_tgt[$];

    core #(.RESET_PC(RESET_PC)) u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_rden  (inst_rden),
        .inst_riaddr(inst_riaddr),
        .inst_roaddr(inst_roaddr),
        .inst_rvalid(inst_rvalid),
        .inst_rdata (inst_rdata),
        .mem_wait   (mem_wait),
        .reg_w_valid(reg_w_valid),
        .reg_w_rd   (reg_w_rd),
        .reg_w_data (reg_w_data)
    );

    // I format, also used for shifts with funct7 in the top bits
    function automatic word_t enc_ri(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                     reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(funct7_t f7, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3,
                                    reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t enc_b(reg_addr_t rs1, reg_addr_t rs2, funct3_t f3, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic word_t enc_j(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    task automatic add_row(word_t inst, bit ret, reg_addr_t rd, word_t val, bit jmp, word_t tgt);
        row_inst.push_back(inst);
        row_ret.push_back(ret);
        row_rd.push_back(rd);
        row_val.push_back(val);
        row_jmp.push_back(jmp);
        row_tgt.push_back(tgt);
    endtask

    // row n sits at address 4n
    task automatic load_program();
        add_row(enc_ri(12'hff9, 0, F3_ADD_SUB, 1, opc_op_imm), 1, 1, 32'hffff_fff9, 0, 0);
        add_row(enc_ri(12'd1, 1, F3_SLT, 2, opc_op_imm), 1, 2, 32'h1, 0, 0);
        add_row(enc_ri(12'd1, 1, F3_SLTU, 3, opc_op_imm), 1, 3, 32'h0, 0, 0);
        add_row(enc_ri(12'h0f0, 1, F3_XOR, 4, opc_op_imm), 1, 4, 32'hffff_ff09, 0, 0);
        add_row(enc_ri(12'h700, 2, F3_OR, 5, opc_op_imm), 1, 5, 32'h701, 0, 0);
        add_row(enc_ri(12'h03c, 1, F3_AND, 6, opc_op_imm), 1, 6, 32'h38, 0, 0);
        add_row(enc_ri(12'd4, 5, F3_SLL, 7, opc_op_imm), 1, 7, 32'h7010, 0, 0);
        add_row(enc_ri(12'd28, 1, F3_SRL_SRA, 8, opc_op_imm), 1, 8, 32'hf, 0, 0);
        add_row(enc_ri(12'h401, 1, F3_SRL_SRA, 9, opc_op_imm), 1, 9, 32'hffff_fffc, 0, 0);
        add_row(enc_r(7'h00, 7, 1, F3_ADD_SUB, 10), 1, 10, 32'h7009, 0, 0);
        // not-taken branches are spread over the register-register ops
        add_row(enc_b(2, 3, F3_BEQ, 13'd8), 0, 0, 0, 0, 0);
        add_row(enc_r(7'h20, 1, 2, F3_ADD_SUB, 11), 1, 11, 32'h8, 0, 0);
        add_row(enc_r(7'h00, 2, 1, F3_SLT, 12), 1, 12, 32'h1, 0, 0);
        add_row(enc_b(2, 12, F3_BNE, 13'd8), 0, 0, 0, 0, 0);
        add_row(enc_r(7'h00, 2, 1, F3_SLTU, 13), 1, 13, 32'h0, 0, 0);
        add_row(enc_b(2, 1, F3_BLT, 13'd8), 0, 0, 0, 0, 0);
        add_row(enc_r(7'h00, 5, 4, F3_XOR, 14), 1, 14, 32'hffff_f808, 0, 0);
        add_row(enc_b(2, 1, F3_BGEU, 13'd8), 0, 0, 0, 0, 0);
        add_row(enc_r(7'h00, 11, 1, F3_SRL_SRA, 15), 1, 15, 32'h00ff_ffff, 0, 0);
        add_row(enc_r(7'h20, 11, 4, F3_SRL_SRA, 16), 1, 16, 32'hffff_ffff, 0, 0);
        add_row(enc_r(7'h00, 8, 6, F3_OR, 17), 1, 17, 32'h3f, 0, 0);
        add_row(enc_r(7'h00, 7, 10, F3_AND, 18), 1, 18, 32'h7000, 0, 0);
        add_row({20'habcde, 5'd19, opc_lui}, 1, 19, 32'habcd_e000, 0, 0);
        add_row({20'h00001, 5'd20, opc_auipc}, 1, 20, 32'h105c, 0, 0);
        add_row(enc_ri(12'd5, 1, F3_ADD_SUB, 0, opc_op_imm), 0, 0, 0, 0, 0);
        // load word, unsupported
        add_row(enc_ri(12'd0, 0, 3'b010, 21, 7'b0000011), 0, 0, 0, 0, 0);
        add_row(enc_r(7'h00, 9, 0, F3_ADD_SUB, 22), 1, 22, 32'hffff_fffc, 0, 0);
        add_row(enc_j(23, 21'd8), 1, 23, 32'h70, 1, 32'h74);
        add_row(enc_ri(12'd1, 0, F3_ADD_SUB, 24, opc_op_imm), 0, 0, 0, 0, 0);
        // odd target, low bit dropped
        add_row(enc_ri(12'h07d, 0, 3'b000, 26, opc_jalr), 1, 26, 32'h78, 1, 32'h7c);
        add_row(enc_ri(12'd2, 0, F3_ADD_SUB, 24, opc_op_imm), 0, 0, 0, 0, 0);
        add_row(enc_b(2, 12, F3_BEQ, 13'd8), 0, 0, 0, 1, 32'h84);
        add_row(enc_ri(12'd5, 0, F3_ADD_SUB, 27, opc_op_imm), 0, 0, 0, 0, 0);
        add_row(enc_b(2, 3, F3_BNE, 13'd8), 0, 0, 0, 1, 32'h8c);
        add_row(enc_ri(12'd6, 0, F3_ADD_SUB, 27, opc_op_imm), 0, 0, 0, 0, 0);
        add_row(enc_b(1, 2, F3_BLT, 13'd8), 0, 0, 0, 1, 32'h94);
        add_row(enc_ri(12'd7, 0, F3_ADD_SUB, 27, opc_op_imm), 0, 0, 0, 0, 0);
        add_row(enc_b(1, 2, F3_BGEU, 13'd8), 0, 0, 0, 1, 32'h9c);
        add_row(enc_ri(12'd8, 0, F3_ADD_SUB, 27, opc_op_imm), 0, 0, 0, 0, 0);
        add_row(enc_ri(12'd9, 0, F3_ADD_SUB, 28, opc_op_imm), 1, 28, 32'h9, 0, 0);
        // park in a jump to itself
        add_row(enc_j(0, 21'd0), 0, 0, 0, 1, 32'ha0);
    endtask

    task automatic check_data(string name, word_t exp, word_t got);
        if (got !== exp) begin
            errors++;
            $display("Error %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_rd(string name, reg_addr_t exp, reg_addr_t got);
        if (got !== exp) begin
            errors++;
            $display("Error %0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic got);
        if (got !== exp) begin
            errors++;
            $display("Error %0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1;
        end
    end

    // memory answers the request seen at the previous edge
    always @(posedge clk) begin
        #2;
        if (rst_n && (cycles >= 2)) begin
            mem_wait = (($urandom % 4) == 0);
        end
        inst_rvalid = req_valid;
        inst_roaddr = req_addr;
        inst_rdata  = rom[req_addr[9:2]];
    end

    always @(negedge clk) begin
        if (rst_n && (cycles >= 1)) begin
            if (cycles == 1) begin
                check_data("inst_riaddr", RESET_PC, inst_riaddr);
            end else if ((due_cyc.size() > 0) && (due_cyc[0] == cycles)) begin
                check_data("inst_riaddr", due_tgt[0], inst_riaddr);
                void'(due_cyc.pop_front());
                void'(due_tgt.pop_front());
            end else begin
                // advance after a request, hold after a stall
                check_data("inst_riaddr", prev_rden ? prev_addr + 32'd4 : prev_addr,
                           inst_riaddr);
            end
            check_bit("inst_rden", ~mem_wait, inst_rden);
            // follow the right path, a jump lands on inst_riaddr three cycles on
            if (inst_rvalid && (inst_roaddr == model_pc)) begin
                row_idx = int'((inst_roaddr - RESET_PC) >> 2);
                if (row_jmp[row_idx]) begin
                    due_cyc.push_back(cycles + 3);
                    due_tgt.push_back(row_tgt[row_idx]);
                    model_pc = row_tgt[row_idx];
                end else begin
                    model_pc = model_pc + 32'd4;
                end
            end
            prev_rden = inst_rden;
            prev_addr = inst_riaddr;
            req_valid = inst_rden;
            req_addr  = inst_riaddr;
            if (reg_w_valid) begin
                if (exp_idx >= exp_rd.size()) begin
                    errors++;
                    $display("Error at %0t: register write retired with no write left to expect",
                             $time);
                end else begin
                    check_rd("reg_w_rd", exp_rd[exp_idx], reg_w_rd);
                    check_data("reg_w_data", exp_val[exp_idx], reg_w_data);
                    exp_idx++;
                end
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        mem_wait    = 1'b0;
        inst_rvalid = 1'b0;
        inst_roaddr = '0;
        inst_rdata  = '0;
        errors      = 0;
        cycles      = 0;
        exp_idx     = 0;
        req_valid   = 1'b0;
        req_addr    = RESET_PC;
        prev_rden   = 1'b0;
        prev_addr   = RESET_PC;
        model_pc    = RESET_PC;
        row_idx     = 0;
        void'($urandom(SEED));
        load_program();
        // unused words decode as loads, pattern from the word index
        for (int i = 0; i < 256; i++) begin
            rom[i] = (word_t'(i) << 7) | 32'h03;
        end
        for (int i = 0; i < row_inst.size(); i++) begin
            rom[i] = row_inst[i];
            if (row_ret[i]) begin
                exp_rd.push_back(row_rd[i]);
                exp_val.push_back(row_val[i]);
            end
        end
        limit = 20 * row_inst.size() + 50;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        while ((exp_idx < exp_rd.size()) && (cycles < limit)) begin
            @(posedge clk);
        end
        // room for any stray retirement
        repeat (10) @(posedge clk);
        if (exp_idx < exp_rd.size()) begin
            errors++;
            $display("Timeout after %0d cycles: %0d expected register writes never retired",
                     cycles, exp_rd.size() - exp_idx);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog/core.sv */
`timescale 1ns/1ns

module core #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,

    // instruction memory
    output logic                inst_rden,
    output core_pkg::word_t     inst_riaddr,
    input  core_pkg::word_t     inst_roaddr,
    input  logic                inst_rvalid,
    input  core_pkg::word_t     inst_rdata,
    input  logic                mem_wait,

    // retire trace
    output logic                reg_w_valid,
    output core_pkg::reg_addr_t reg_w_rd,
    output core_pkg::word_t     reg_w_data
);
    import core_pkg::*;

    word_t     rs1_v;
    word_t     rs2_v;
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
    logic      jmp_do;
    word_t     jmp_pc;

    exec_bus_if exec_bus ();

    fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_wait   (mem_wait),
        .jmp_do     (jmp_do),
        .jmp_pc     (jmp_pc),
        .inst_rden  (inst_rden),
        .inst_riaddr(inst_riaddr)
    );

    // memory response goes straight into decode
    decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_valid(inst_rvalid),
        .inst_pc   (inst_roaddr),
        .inst_data (inst_rdata),
        .bus       (exec_bus.producer)
    );

    register u_register (
        .clk  (clk),
        .rst_n(rst_n),
        .we   (we),
        .waddr(waddr),
        .wdata(wdata),
        .bus  (exec_bus.reg_read),
        .rs1_v(rs1_v),
        .rs2_v(rs2_v)
    );

    exec #(.RESET_PC(RESET_PC)) u_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_v      (rs1_v),
        .rs2_v      (rs2_v),
        .bus        (exec_bus.consumer),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .reg_w_valid(reg_w_valid),
        .reg_w_rd   (reg_w_rd),
        .reg_w_data (reg_w_data),
        .jmp_do     (jmp_do),
        .jmp_pc     (jmp_pc)
    );

endmodule

/* verilog/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        // only for S immediate selection, retires as no-op
        opc_store  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    // funct7 bit selecting sub / sra
    localparam int F7_ALT_BIT = 5;

    // alu funct3
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

endpackage

/* verilog/decode.sv */
`timescale 1ns/1ns

module decode (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inst_valid,
    input  core_pkg::word_t inst_pc,
    input  core_pkg::word_t inst_data,
    exec_bus_if.producer    bus
);
    import core_pkg::*;

    opcode_e opcode;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    word_t   imm_sel;

    assign opcode = opcode_e'(inst_data[OPCODE_LSB +: 7]);

    // immediates per format, sign from bit 31
    assign imm_i = {{20{inst_data[31]}}, inst_data[31:20]};
    assign imm_s = {{20{inst_data[31]}}, inst_data[31:25], inst_data[11:7]};
    assign imm_b = {
        {19{inst_data[31]}},
        inst_data[31],
        inst_data[7],
        inst_data[30:25],
        inst_data[11:8],
        1'b0
    };
    assign imm_u = {inst_data[31:12], 12'b0};
    assign imm_j = {
        {11{inst_data[31]}},
        inst_data[31],
        inst_data[19:12],
        inst_data[20],
        inst_data[30:21],
        1'b0
    };

    always_comb begin
        case (opcode)
            opc_lui,
            opc_auipc: begin
                imm_sel = imm_u;
            end
            opc_jal: begin
                imm_sel = imm_j;
            end
            opc_branch: begin
                imm_sel = imm_b;
            end
            opc_store: begin
                imm_sel = imm_s;
            end
            // op_imm, jalr, loads and the rest
            default: begin
                imm_sel = imm_i;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            bus.pc     <= inst_pc;
            bus.opcode <= opcode;
            bus.rd     <= inst_data[RD_LSB +: 5];
            bus.rs1    <= inst_data[RS1_LSB +: 5];
            bus.rs2    <= inst_data[RS2_LSB +: 5];
            bus.funct3 <= inst_data[FUNCT3_LSB +: 3];
            bus.funct7 <= inst_data[FUNCT7_LSB +: 7];
            bus.imm    <= imm_sel;
        end
    end

endmodule

/* verilog/exec.sv */
`timescale 1ns/1ns

module exec #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::word_t     rs1_v,
    input  core_pkg::word_t     rs2_v,
    exec_bus_if.consumer        bus,
    output logic                we,
    output core_pkg::reg_addr_t waddr,
    output core_pkg::word_t     wdata,
    output logic                reg_w_valid,
    output core_pkg::reg_addr_t reg_w_rd,
    output core_pkg::word_t     reg_w_data,
    output logic                jmp_do,
    output core_pkg::word_t     jmp_pc
);
    import core_pkg::*;

    alu_op_e alu_op;
    word_t   op_b;
    word_t   alu_res;
    word_t   pc_imm;
    word_t   link;
    word_t   result;
    word_t   target;
    word_t   exp_pc;
    logic    br_taken;
    logic    writes;
    logic    redirect;
    logic    issue;

    always_comb begin
        alu_op = alu_add;
        if ((bus.opcode == opc_op) || (bus.opcode == opc_op_imm)) begin
            case (bus.funct3)
                F3_ADD_SUB: begin
                    if ((bus.opcode == opc_op) && bus.funct7[F7_ALT_BIT]) begin
                        alu_op = alu_sub;
                    end
                end
                F3_SLL:  alu_op = alu_sll;
                F3_SLT:  alu_op = alu_slt;
                F3_SLTU: alu_op = alu_sltu;
                F3_XOR:  alu_op = alu_xor;
                F3_SRL_SRA: begin
                    alu_op = bus.funct7[F7_ALT_BIT] ? alu_sra : alu_srl;
                end
                F3_OR:   alu_op = alu_or;
                F3_AND:  alu_op = alu_and;
                default: alu_op = alu_add;
            endcase
        end
    end

    assign op_b = (bus.opcode == opc_op_imm) ? bus.imm : rs2_v;

    always_comb begin
        case (alu_op)
            alu_add:  alu_res = rs1_v + op_b;
            alu_sub:  alu_res = rs1_v - op_b;
            alu_sll:  alu_res = rs1_v << op_b[4:0];
            alu_slt:  alu_res = {31'b0, ($signed(rs1_v) < $signed(op_b))};
            alu_sltu: alu_res = {31'b0, (rs1_v < op_b)};
            alu_xor:  alu_res = rs1_v ^ op_b;
            alu_srl:  alu_res = rs1_v >> op_b[4:0];
            alu_sra:  alu_res = $signed(rs1_v) >>> op_b[4:0];
            alu_or:   alu_res = rs1_v | op_b;
            alu_and:  alu_res = rs1_v & op_b;
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (bus.funct3)
            F3_BEQ:  br_taken = (rs1_v == rs2_v);
            F3_BNE:  br_taken = (rs1_v != rs2_v);
            F3_BLT:  br_taken = ($signed(rs1_v) < $signed(rs2_v));
            F3_BGE:  br_taken = ($signed(rs1_v) >= $signed(rs2_v));
            F3_BLTU: br_taken = (rs1_v < rs2_v);
            F3_BGEU: br_taken = (rs1_v >= rs2_v);
            default: br_taken = 1'b0;
        endcase
    end

    assign pc_imm = bus.pc + bus.imm;
    assign link   = bus.pc + 32'd4;

    always_comb begin
        result   = alu_res;
        target   = pc_imm;
        writes   = 1'b0;
        redirect = 1'b0;
        case (bus.opcode)
            opc_op,
            opc_op_imm: writes = 1'b1;
            opc_lui: begin
                result = bus.imm;
                writes = 1'b1;
            end
            opc_auipc: begin
                result = pc_imm;
                writes = 1'b1;
            end
            opc_jal: begin
                result   = link;
                writes   = 1'b1;
                redirect = 1'b1;
            end
            opc_jalr: begin
                result   = link;
                target   = (rs1_v + bus.imm) & ~32'd1;
                writes   = 1'b1;
                redirect = 1'b1;
            end
            opc_branch: redirect = br_taken;
            // loads, stores, fence, system retire silently
            default: writes = 1'b0;
        endcase
    end

    // drop anything fetched down the wrong path
    assign issue = bus.valid && (bus.pc == exp_pc);

    assign we    = issue && writes && (bus.rd != '0);
    assign waddr = bus.rd;
    assign wdata = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc      <= RESET_PC;
            reg_w_valid <= 1'b0;
            jmp_do      <= 1'b0;
        end else begin
            reg_w_valid <= we;
            jmp_do      <= issue && redirect;
            if (issue) begin
                exp_pc <= redirect ? target : link;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            reg_w_rd   <= bus.rd;
            reg_w_data <= result;
        end
        if (issue && redirect) begin
            jmp_pc <= target;
        end
    end

endmodule

/* verilog/exec_bus_if.sv */
`timescale 1ns/1ns

interface exec_bus_if;
    import core_pkg::*;

    logic      valid;
    word_t     pc;
    opcode_e   opcode;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    funct3_t   funct3;
    funct7_t   funct7;
    word_t     imm;

    modport producer (
        output valid, pc, opcode, rd, rs1, rs2, funct3, funct7, imm
    );

    modport consumer (
        input valid, pc, opcode, rd, rs1, rs2, funct3, funct7, imm
    );

    // register file only needs the source indices
    modport reg_read (
        input rs1, rs2
    );

endinterface

/* verilog/fetch.sv */
`timescale 1ns/1ns

module fetch #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mem_wait,
    input  logic            jmp_do,
    input  core_pkg::word_t jmp_pc,
    output logic            inst_rden,
    output core_pkg::word_t inst_riaddr
);
    import core_pkg::*;

    logic  active;
    word_t next_addr;

    // requests start one edge after reset release
    assign inst_rden = active & ~mem_wait;

    always_comb begin
        if (jmp_do) begin
            // redirect wins over the stall
            next_addr = jmp_pc;
        end else if (inst_rden) begin
            next_addr = inst_riaddr + 32'd4;
        end else begin
            next_addr = inst_riaddr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active      <= 1'b0;
            inst_riaddr <= RESET_PC;
        end else begin
            active      <= 1'b1;
            inst_riaddr <= next_addr;
        end
    end

endmodule

/* verilog/register.sv */
`timescale 1ns/1ns

module register (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata,
    exec_bus_if.reg_read        bus,
    output core_pkg::word_t     rs1_v,
    output core_pkg::word_t     rs2_v
);
    import core_pkg::*;

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        if (bus.rs1 == '0) begin
            rs1_v = '0;
        end else begin
            rs1_v = regs[bus.rs1];
        end
        if (bus.rs2 == '0) begin
            rs2_v = '0;
        end else begin
            rs2_v = regs[bus.rs2];
        end
    end

endmodule
